// ==== verilog/i2s_pkg.sv ====
/*
 * i2s transmit package
 * format constants, counter widths and the structs passed
 * between the sample queue, frame timing and shifter
 */

package i2s_pkg;

	// ==============================
	// serial format
	// ==============================
	localparam int SAMPLE_WIDTH = 24;	// bits per channel word
	localparam int SLOT_WIDTH = 32;	// sck periods per channel slot
	localparam int FRAME_BITS = 2 * SLOT_WIDTH;	// 64 sck periods per frame
	localparam int SCK_HALF_PERIOD = 2;	// bclk cycles per sck half period
	localparam int FIFO_DEPTH = 4;

	// counter widths
	localparam int HALF_CNT_W = (SCK_HALF_PERIOD > 1) ? $clog2(SCK_HALF_PERIOD) : 1;
	localparam int SLOT_CNT_W = $clog2(FRAME_BITS);
	localparam int POS_W = $clog2(SLOT_WIDTH);	// bit position inside one channel slot

	// terminal and decode values, sized to their counters
	localparam logic [HALF_CNT_W-1:0] HALF_LAST = HALF_CNT_W'(SCK_HALF_PERIOD - 1);
	localparam logic [SLOT_CNT_W-1:0] SLOT_LAST = SLOT_CNT_W'(FRAME_BITS - 1);
	localparam logic [POS_W-1:0] FIRST_DATA_POS = POS_W'(1);	// one bit after lrclk edge
	localparam logic [POS_W-1:0] LAST_DATA_POS = POS_W'(SAMPLE_WIDTH);

	// ==============================
	// types
	// ==============================
	typedef struct packed {
		logic [SAMPLE_WIDTH-1:0] left;	// upper half
		logic [SAMPLE_WIDTH-1:0] right;
	} stereo_sample_t;

	// per slot command, only meaningful while fall is set
	typedef struct packed {
		logic fall;	// sck falls at the end of this bclk cycle
		logic frame_start;	// slot 0
		logic load_left;	// slot 1, left msb
		logic load_right;	// slot 33, right msb
		logic shift;	// remaining data slots
		logic blank;	// padding, sends zero
	} bit_cmd_t;

endpackage

// ==== verilog/sample_fifo.sv ====
/*
 * sample queue
 * small register fifo with valid/ready on both sides,
 * head entry shown combinationally on the pop side
 */

module sample_fifo #(
	parameter type payload_t = i2s_pkg::stereo_sample_t,
	parameter int depth = i2s_pkg::FIFO_DEPTH
) (
	input  logic     bclk,
	input  logic     rst,
	input  logic     in_valid,
	input  logic     pop_ready,
	input  payload_t in_sample,
	output logic     in_ready,
	output logic     pop_valid,
	output payload_t pop_sample
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	localparam logic [ptr_w-1:0] ptr_last = ptr_w'(depth - 1);
	localparam logic [cnt_w-1:0] cnt_full = cnt_w'(depth);

	payload_t mem [depth];	// sample storage

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;	// occupancy

	logic push;
	logic pop;

	// ==============================
	// handshake
	// ==============================
	assign in_ready = (count != cnt_full);
	assign pop_valid = (count != '0);
	assign pop_sample = mem[rd_ptr];	// head of queue

	assign push = in_valid & in_ready;
	assign pop = pop_valid & pop_ready;

	// ==============================
	// storage
	// ==============================
	always_ff @(posedge bclk) begin
		if (push) begin
			mem[wr_ptr] <= in_sample;
		end
	end

	// pointers wrap at depth, not only at powers of two
	always_ff @(posedge bclk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// occupancy, push and pop together leave it unchanged
	always_ff @(posedge bclk) begin
		if (!rst) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== verilog/i2s_frame_timing.sv ====
/*
 * i2s frame timing
 * divides bclk down to sck, counts the 64 bit slots of a frame,
 * drives lrclk and decodes each slot into a shifter command
 */

module i2s_frame_timing (
	input  logic              bclk,
	input  logic              rst,
	output logic              sck,
	output logic              lrclk,
	output i2s_pkg::bit_cmd_t cmd
);

	logic [i2s_pkg::HALF_CNT_W-1:0] half_cnt;	// bclk cycles within sck half
	logic [i2s_pkg::SLOT_CNT_W-1:0] slot;	// current bit slot
	logic [i2s_pkg::SLOT_CNT_W-1:0] slot_next;	// slot begun at next fall
	logic [i2s_pkg::POS_W-1:0] pos;	// position inside channel slot

	logic half_done;
	logic fall;
	logic right_half;
	logic in_data;
	logic first_bit;

	// ==============================
	// sck divider
	// ==============================
	assign half_done = (half_cnt == i2s_pkg::HALF_LAST);
	assign fall = half_done & sck;	// sck high, about to drop

	always_ff @(posedge bclk) begin
		if (!rst) begin
			half_cnt <= '0;
			sck <= 1'b0;
		end else begin
			if (half_done) begin
				half_cnt <= '0;
				sck <= ~sck;
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	// ==============================
	// slot counter
	// ==============================
	// starts at the last slot so the first fall opens slot 0
	always_ff @(posedge bclk) begin
		if (!rst) begin
			slot <= i2s_pkg::SLOT_LAST;
		end else if (fall) begin
			slot <= slot_next;
		end
	end

	assign slot_next = slot + 1'b1;	// wraps 63 -> 0

	// lrclk changes with sdata, while sck goes low
	always_ff @(posedge bclk) begin
		if (!rst) begin
			lrclk <= 1'b0;
		end else if (fall) begin
			lrclk <= right_half;
		end
	end

	// ==============================
	// slot decode
	// ==============================
	assign right_half = slot_next[i2s_pkg::SLOT_CNT_W-1];	// slots 32..63
	assign pos = slot_next[i2s_pkg::POS_W-1:0];

	// data sits one bit after the lrclk edge, 24 bits long
	assign first_bit = (pos == i2s_pkg::FIRST_DATA_POS);
	assign in_data = (pos >= i2s_pkg::FIRST_DATA_POS) && (pos <= i2s_pkg::LAST_DATA_POS);

	always_comb begin
		cmd = '0;
		cmd.fall = fall;
		if (fall) begin
			cmd.frame_start = (slot_next == '0);
			cmd.load_left = first_bit & ~right_half;
			cmd.load_right = first_bit & right_half;
			cmd.shift = in_data & ~first_bit;
			cmd.blank = ~in_data;	// includes slots 0 and 32
		end
	end

endmodule

// ==== verilog/i2s_shifter.sv ====
/*
 * i2s shifter
 * takes one stereo pair per frame from the queue and shifts
 * both channel words out msb first, flags an empty queue
 */

module i2s_shifter (
	input  logic                    bclk,
	input  logic                    rst,
	input  i2s_pkg::bit_cmd_t       cmd,
	input  logic                    pop_valid,
	input  i2s_pkg::stereo_sample_t pop_sample,
	output logic                    pop_ready,
	output logic                    sdata,
	output logic                    underrun
);

	localparam int msb = i2s_pkg::SAMPLE_WIDTH - 1;

	i2s_pkg::stereo_sample_t hold;	// pair for the current frame
	logic [msb-1:0] shreg;	// bits left after the msb

	logic take;	// frame start strobe

	// ==============================
	// queue side
	// ==============================
	assign take = cmd.fall & cmd.frame_start;

	// one request per frame
	assign pop_ready = take;

	// nothing queued when the frame opens
	assign underrun = take & ~pop_valid;

	// silent frame on underrun
	always_ff @(posedge bclk) begin
		if (take) begin
			if (pop_valid) begin
				hold <= pop_sample;
			end else begin
				hold <= '0;
			end
		end
	end

	// ==============================
	// shift register
	// ==============================
	// loaded with the lower bits while the msb goes straight to sdata
	always_ff @(posedge bclk) begin
		if (cmd.fall) begin
			if (cmd.load_left) begin
				shreg <= hold.left[msb-1:0];
			end else if (cmd.load_right) begin
				shreg <= hold.right[msb-1:0];
			end else if (cmd.shift) begin
				shreg <= {shreg[msb-2:0], 1'b0};
			end
		end
	end

	// ==============================
	// serial output
	// ==============================
	/*
	 * sdata only moves in fall cycles, so it settles
	 * half an sck period before the receiver samples
	 */
	always_ff @(posedge bclk) begin
		if (!rst) begin
			sdata <= 1'b0;
		end else if (cmd.fall) begin
			if (cmd.load_left) begin
				sdata <= hold.left[msb];	// left msb
			end else if (cmd.load_right) begin
				sdata <= hold.right[msb];	// right msb
			end else if (cmd.shift) begin
				sdata <= shreg[msb-1];
			end else if (cmd.blank) begin
				sdata <= 1'b0;	// padding slots
			end
		end
	end

endmodule

// ==== verilog/i2s_tx_top.sv ====
/*
 * i2s transmitter top
 * sample queue, frame timing and shifter for a 24 bit stereo
 * output, all on bclk
 */

module i2s_tx_top (
	input  logic                    bclk,
	input  logic                    rst,
	input  logic                    in_valid,
	input  i2s_pkg::stereo_sample_t in_sample,
	output logic                    in_ready,
	output logic                    sck,
	output logic                    lrclk,
	output logic                    sdata,
	output logic                    underrun
);

	// queue to shifter
	i2s_pkg::stereo_sample_t pop_sample;
	logic pop_valid;
	logic pop_ready;

	// timing to shifter
	i2s_pkg::bit_cmd_t cmd;

	// ==============================
	// sample queue
	// ==============================
	sample_fifo #(
		.payload_t (i2s_pkg::stereo_sample_t),
		.depth     (i2s_pkg::FIFO_DEPTH)
	) u_fifo (
		.bclk       (bclk),
		.rst        (rst),
		.in_valid   (in_valid),
		.pop_ready  (pop_ready),
		.in_sample  (in_sample),
		.in_ready   (in_ready),
		.pop_valid  (pop_valid),
		.pop_sample (pop_sample)
	);

	// slot decode
	i2s_frame_timing u_timing (
		.bclk  (bclk),
		.rst   (rst),
		.sck   (sck),
		.lrclk (lrclk),
		.cmd   (cmd)
	);

	// word load and shift
	i2s_shifter u_shifter (
		.bclk       (bclk),
		.rst        (rst),
		.cmd        (cmd),
		.pop_valid  (pop_valid),
		.pop_sample (pop_sample),
		.pop_ready  (pop_ready),
		.sdata      (sdata),
		.underrun   (underrun)
	);

endmodule

// ==== bench/i2s_tx_checker.sv ====
/*
 * i2s transmit checker
 * watches the serial pins on bclk, rebuilds both words of each
 * frame and compares them with the pairs the dut accepted
 */

module i2s_tx_checker (
	input logic bclk,
	input logic rst,
	input logic in_ready,
	input logic sck,
	input logic lrclk,
	input logic sdata,
	input logic underrun
);

	localparam int sck_period = 2 * i2s_pkg::SCK_HALF_PERIOD;	// bclk cycles
	localparam int w = i2s_pkg::SAMPLE_WIDTH;
	localparam int last_slot = i2s_pkg::FRAME_BITS - 1;

	int pass_count = 0;
	int fail_count = 0;

	// pairs accepted by the dut in arrival order
	string exp_name [$];
	i2s_pkg::stereo_sample_t exp_pair [$];

	int slot;
	int frame;
	int since_rise;	// bclk cycles since last sck rise
	int full_cycles;	// cycles with in_ready low
	bit started;
	bit have_rise;
	bit silent;	// current frame opened with underrun
	bit underrun_seen;
	logic prev_rst;
	logic prev_sck;
	logic prev_lrclk;
	logic prev_sdata;
	logic prev_underrun;
	logic [w-1:0] got_left;
	logic [w-1:0] got_right;

	task automatic expect_pair(input string name, input i2s_pkg::stereo_sample_t pair);
		exp_name.push_back(name);
		exp_pair.push_back(pair);
	endtask

	function automatic int pending_count();
		return exp_pair.size();
	endfunction

	task automatic report_error(input string what);
		fail_count++;
		$display("Error frame %0d slot %0d: %s", frame, slot, what);
	endtask

	// ==============================
	// frame compare
	// ==============================
	task automatic compare_frame();
		string name;
		i2s_pkg::stereo_sample_t want;
		if (silent) begin
			if ({got_left, got_right} !== '0) begin
				fail_count++;
				$display("Mismatch test underrun frame %0d expected %h actual %h",
					frame, 48'h0, {got_left, got_right});
			end else begin
				pass_count++;
				$display("frame %0d underrun, silent frame ok", frame);
			end
		end else if (exp_pair.size() == 0) begin
			report_error("frame started without underrun but no pair was pending");
		end else begin
			name = exp_name.pop_front();
			want = exp_pair.pop_front();
			if ({got_left, got_right} !== want) begin
				fail_count++;
				$display("Mismatch test %s frame %0d expected %h actual %h",
					name, frame, want, {got_left, got_right});
			end else begin
				pass_count++;
				$display("frame %0d test %s ok %h", frame, name, want);
			end
		end
	endtask

	// one serial bit taken at the sck rise
	task automatic sample_bit();
		if (lrclk !== (slot >= i2s_pkg::SLOT_WIDTH)) begin
			report_error("lrclk on the wrong channel for this slot");
		end
		if (slot >= 1 && slot <= w) begin
			got_left[w - slot] = sdata;	// msb first
		end else if (slot >= i2s_pkg::SLOT_WIDTH + 1 && slot <= i2s_pkg::SLOT_WIDTH + w) begin
			got_right[w - (slot - i2s_pkg::SLOT_WIDTH)] = sdata;
		end else if (sdata !== 1'b0) begin
			report_error("padding slot is not zero");
		end
		if (slot == last_slot) begin
			compare_frame();
			frame++;
		end
	endtask

	task automatic check_reset_state();
		if (sck !== 1'b0 || lrclk !== 1'b0 || sdata !== 1'b0 || underrun !== 1'b0) begin
			report_error("serial outputs are not low after reset");
		end else if (in_ready !== 1'b1) begin
			report_error("in_ready is not high after reset");
		end else begin
			pass_count++;
			$display("reset state ok");
		end
	endtask

	task automatic finish_checks();
		if (full_cycles == 0) begin
			report_error("in_ready never went low during the burst");
		end
	endtask

	// ==============================
	// pin monitor
	// ==============================
	always @(posedge bclk) begin
		if (!rst) begin
			slot = last_slot;	// first fall opens slot 0
			frame = 0;
			since_rise = 0;
			full_cycles = 0;
			started = 1'b0;
			have_rise = 1'b0;
			silent = 1'b0;
			underrun_seen = 1'b0;
		end else begin
			if (!prev_rst) begin
				check_reset_state();
			end
			if (!in_ready) begin
				full_cycles++;
			end
			since_rise++;
			if (underrun) begin
				if (!(sck && slot == last_slot)) begin
					report_error("underrun pulse away from a frame start");
				end
				if (prev_underrun) begin
					report_error("underrun pulse longer than one bclk cycle");
				end
				underrun_seen = 1'b1;
			end
			// pins may only move together with the sck fall
			if (lrclk !== prev_lrclk && !(prev_sck && !sck)) begin
				report_error("lrclk changed away from an sck fall");
			end
			if (sdata !== prev_sdata && !(prev_sck && !sck)) begin
				report_error("sdata changed away from an sck fall");
			end
			if (prev_sck && !sck) begin
				slot = (slot + 1) % i2s_pkg::FRAME_BITS;
				if (slot == 0) begin	// new frame
					started = 1'b1;
					silent = underrun_seen;
					underrun_seen = 1'b0;
					got_left = '0;
					got_right = '0;
				end
			end
			if (!prev_sck && sck) begin
				if (have_rise && since_rise != sck_period) begin
					report_error("sck period is not 4 bclk cycles");
				end
				have_rise = 1'b1;
				since_rise = 0;
				if (started) begin
					sample_bit();
				end
			end
		end
		prev_rst = rst;
		prev_sck = sck;
		prev_lrclk = lrclk;
		prev_sdata = sdata;
		prev_underrun = underrun;
	end

endmodule

// ==== bench/i2s_tx_tb.sv ====
/*
 * i2s transmitter testbench
 * offers a table of stereo pairs with idle gaps to the dut,
 * the checker instance rebuilds and compares the frames
 */

module i2s_tx_tb;

	localparam int num_tests = 12;
	localparam int frame_cycles = i2s_pkg::FRAME_BITS * 2 * i2s_pkg::SCK_HALF_PERIOD;

	logic bclk;
	logic rst;
	logic in_valid;
	i2s_pkg::stereo_sample_t in_sample;
	logic in_ready;
	logic sck;
	logic lrclk;
	logic sdata;
	logic underrun;

	// stimulus table
	string test_name [num_tests];
	i2s_pkg::stereo_sample_t test_pair [num_tests];
	int test_gap [num_tests];	// idle bclk cycles before the entry

	integer seed = 32'h5b7d5369;
	int cycle_count = 0;
	int cycle_limit = 0;

	initial bclk = 1'b0;
	always #4 bclk = ~bclk;

	i2s_tx_top u_dut (
		.bclk      (bclk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_sample (in_sample),
		.in_ready  (in_ready),
		.sck       (sck),
		.lrclk     (lrclk),
		.sdata     (sdata),
		.underrun  (underrun)
	);

	i2s_tx_checker u_check (
		.bclk     (bclk),
		.rst      (rst),
		.in_ready (in_ready),
		.sck      (sck),
		.lrclk    (lrclk),
		.sdata    (sdata),
		.underrun (underrun)
	);

	function automatic i2s_pkg::stereo_sample_t random_pair();
		logic [31:0] r;
		i2s_pkg::stereo_sample_t pair;
		r = $random(seed);
		pair.left = r[i2s_pkg::SAMPLE_WIDTH-1:0];
		r = $random(seed);
		pair.right = r[i2s_pkg::SAMPLE_WIDTH-1:0];
		return pair;
	endfunction

	task automatic set_entry(input int idx, input string name,
			input i2s_pkg::stereo_sample_t pair, input int gap);
		test_name[idx] = name;
		test_pair[idx] = pair;
		test_gap[idx] = gap;
	endtask

	// ==============================
	// timeout
	// ==============================
	always @(posedge bclk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("run hung, no result after %0d bclk cycles", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	// ==============================
	// stimulus
	// ==============================
	initial begin
		rst = 1'b0;
		in_valid = 1'b0;
		in_sample = '0;

		// name, pair, gap; entries 0 to 7 form a burst deeper than the queue
		set_entry(0, "all_ones", {24'hffffff, 24'hffffff}, 0);
		set_entry(1, "alt_bits", {24'haaaaaa, 24'h555555}, 0);
		set_entry(2, "msb_only", {24'h800000, 24'h800000}, 0);
		set_entry(3, "lsb_only", {24'h000001, 24'h000001}, 0);
		set_entry(4, "burst_rand_0", random_pair(), 0);
		set_entry(5, "burst_rand_1", random_pair(), 0);
		set_entry(6, "burst_rand_2", random_pair(), 0);
		set_entry(7, "burst_rand_3", random_pair(), 0);
		set_entry(8, "after_gap", {24'h123456, 24'hfedcba}, 1800);	// underrun frames
		set_entry(9, "rand_a", random_pair(), 0);
		set_entry(10, "rand_b", random_pair(), 300);
		set_entry(11, "zero_pair", '0, 0);

		cycle_limit = (num_tests + 4) * frame_cycles;
		for (int i = 0; i < num_tests; i++) begin
			cycle_limit += test_gap[i];
		end

		repeat (2) @(posedge bclk);
		rst <= 1'b1;

		for (int i = 0; i < num_tests; i++) begin
			if (test_gap[i] > 0) begin
				in_valid <= 1'b0;
				repeat (test_gap[i]) @(posedge bclk);
			end
			in_sample <= test_pair[i];
			in_valid <= 1'b1;
			@(posedge bclk);
			while (!in_ready) @(posedge bclk);
			u_check.expect_pair(test_name[i], test_pair[i]);	// taken at this edge
		end
		in_valid <= 1'b0;

		while (u_check.pending_count() != 0) @(posedge bclk);
		repeat (8) @(posedge bclk);
		u_check.finish_checks();

		$display("checks passed %0d failed %0d", u_check.pass_count, u_check.fail_count);
		if (u_check.fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/i2s_pkg.sv
verilog/sample_fifo.sv
verilog/i2s_frame_timing.sv
verilog/i2s_shifter.sv
verilog/i2s_tx_top.sv
bench/i2s_tx_checker.sv
bench/i2s_tx_tb.sv
